// ==== Bender.yml ====
package:
  name: mycpu

sources:
  - files:
      - cpuPkg.sv
      - regFile.sv
      - fetchStage.sv
      - decodeStage.sv
      - executeStage.sv
      - memoryStage.sv
      - hazardUnit.sv
      - mycpuTop.sv
  - target: test
    files:
      - mycpuProps.sv
      - tbMycpu.sv

// ==== cpuPkg.sv ====
package cpuPkg;

	localparam int dataW = 32; // Machine word.
	localparam int regAddrW = 5;
	localparam int physAddrBits = 29; // Low data address bits kept by the fixed mapping.

	typedef enum logic [5:0] {
		SPECIAL = 6'h00,
		J       = 6'h02,
		BEQ     = 6'h04,
		BNE     = 6'h05,
		ADDIU   = 6'h09,
		SLTI    = 6'h0a,
		ANDI    = 6'h0c,
		ORI     = 6'h0d,
		LUI     = 6'h0f,
		LW      = 6'h23,
		SW      = 6'h2b
	} opcodeE;

	typedef enum logic [5:0] {
		ADDU = 6'h21,
		SUBU = 6'h23,
		AND  = 6'h24,
		OR   = 6'h25,
		XOR  = 6'h26,
		NOR  = 6'h27,
		SLT  = 6'h2a,
		SLTU = 6'h2b
	} functE;

	typedef enum logic [3:0] {
		aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor, aluSlt, aluSltu, aluLui
	} aluOpE;

	typedef enum logic [1:0] {
		fromReg, fromMem, fromWb
	} fwdSelE;

endpackage

// ==== decodeStage.sv ====
module decodeStage (
	input  logic                         clk,
	input  logic                         rst_i,
	input  logic                         stallD_i,
	input  logic                         flushD_i,
	input  logic                         flushE_i,
	input  logic [cpuPkg::dataW-1:0]    instr_i,
	input  logic [cpuPkg::dataW-1:0]    pcPlus4F_i,
	input  logic [cpuPkg::dataW-1:0]    pcF_i,
	input  logic                         wbWen_i,
	input  logic [cpuPkg::regAddrW-1:0] wbAddr_i,
	input  logic [cpuPkg::dataW-1:0]    wbData_i,
	output logic [cpuPkg::regAddrW-1:0] rsD_o,
	output logic [cpuPkg::regAddrW-1:0] rtD_o,
	output cpuPkg::aluOpE               aluOpE_o,
	output logic                         useImmE_o,
	output logic                         regWriteE_o,
	output logic                         memReadE_o,
	output logic                         memWriteE_o,
	output logic                         branchE_o,
	output logic                         branchNeE_o,
	output logic                         jumpE_o,
	output logic [cpuPkg::regAddrW-1:0] rsE_o,
	output logic [cpuPkg::regAddrW-1:0] rtE_o,
	output logic [cpuPkg::regAddrW-1:0] destE_o,
	output logic [cpuPkg::dataW-1:0]    srcAE_o,
	output logic [cpuPkg::dataW-1:0]    srcBE_o,
	output logic [cpuPkg::dataW-1:0]    immE_o,
	output logic [cpuPkg::dataW-1:0]    targetE_o,
	output logic [cpuPkg::dataW-1:0]    pcE_o
);

	cpuPkg::aluOpE aluOpD;
	logic useImmD, regWriteD, memReadD, memWriteD, branchD, branchNeD, jumpD;
	logic zeroExtD, rdDestD, validD, bubble;
	logic [cpuPkg::regAddrW-1:0] destD;
	logic [15:0] imm16;
	logic [cpuPkg::dataW-1:0] pcD, pcPlus4D, immD, targetD, rdataA, rdataB;

	regFile i_regFile (
		.clk(clk), .rst_i(rst_i),
		.raddrA_i(rsD_o), .raddrB_i(rtD_o),
		.waddr_i(wbAddr_i), .wen_i(wbWen_i), .wdata_i(wbData_i),
		.rdataA_o(rdataA), .rdataB_o(rdataB)
	);

	// The SRAM output is the instruction half of this register.
	always_ff @(posedge clk) begin
		if (rst_i) begin
			validD <= 1'b0;
		end else begin
			validD <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!stallD_i) begin
			pcD <= pcF_i;
			pcPlus4D <= pcPlus4F_i;
		end
	end

	assign rsD_o = instr_i[25:21];
	assign rtD_o = instr_i[20:16];
	assign imm16 = instr_i[15:0];

	always_comb begin
		aluOpD = cpuPkg::aluAdd;
		{useImmD, regWriteD, memReadD, memWriteD} = '0;
		{branchD, branchNeD, jumpD, zeroExtD, rdDestD} = '0;
		case (cpuPkg::opcodeE'(instr_i[31:26]))
			cpuPkg::SPECIAL: begin
				regWriteD = 1'b1;
				rdDestD = 1'b1;
				case (cpuPkg::functE'(instr_i[5:0]))
					cpuPkg::ADDU: aluOpD = cpuPkg::aluAdd;
					cpuPkg::SUBU: aluOpD = cpuPkg::aluSub;
					cpuPkg::AND:  aluOpD = cpuPkg::aluAnd;
					cpuPkg::OR:   aluOpD = cpuPkg::aluOr;
					cpuPkg::XOR:  aluOpD = cpuPkg::aluXor;
					cpuPkg::NOR:  aluOpD = cpuPkg::aluNor;
					cpuPkg::SLT:  aluOpD = cpuPkg::aluSlt;
					cpuPkg::SLTU: aluOpD = cpuPkg::aluSltu;
					default:      regWriteD = 1'b0; // Includes sll zero, the nop.
				endcase
			end
			cpuPkg::ADDIU: {useImmD, regWriteD} = 2'b11;
			cpuPkg::SLTI: begin
				{useImmD, regWriteD} = 2'b11;
				aluOpD = cpuPkg::aluSlt;
			end
			cpuPkg::ANDI: begin
				{useImmD, regWriteD, zeroExtD} = 3'b111;
				aluOpD = cpuPkg::aluAnd;
			end
			cpuPkg::ORI: begin
				{useImmD, regWriteD, zeroExtD} = 3'b111;
				aluOpD = cpuPkg::aluOr;
			end
			cpuPkg::LUI: begin
				{useImmD, regWriteD} = 2'b11;
				aluOpD = cpuPkg::aluLui;
			end
			cpuPkg::LW:  {useImmD, regWriteD, memReadD} = 3'b111;
			cpuPkg::SW:  {useImmD, memWriteD} = 2'b11;
			cpuPkg::BEQ: branchD = 1'b1;
			cpuPkg::BNE: {branchD, branchNeD} = 2'b11;
			cpuPkg::J:   jumpD = 1'b1;
			default: ; // Unknown opcode retires as a nop.
		endcase
	end

	assign immD = zeroExtD ? {16'b0, imm16} : {{16{imm16[15]}}, imm16};
	assign targetD = jumpD ? {pcPlus4D[31:28], instr_i[25:0], 2'b00}
		: pcPlus4D + {immD[cpuPkg::dataW-3:0], 2'b00};
	assign destD = rdDestD ? instr_i[15:11] : rtD_o;
	assign bubble = flushE_i || flushD_i || !validD;

	always_ff @(posedge clk) begin
		if (rst_i || bubble) begin
			{regWriteE_o, memReadE_o, memWriteE_o} <= '0;
			{branchE_o, branchNeE_o, jumpE_o} <= '0;
		end else begin
			{regWriteE_o, memReadE_o, memWriteE_o} <= {regWriteD, memReadD, memWriteD};
			{branchE_o, branchNeE_o, jumpE_o} <= {branchD, branchNeD, jumpD};
		end
	end

	always_ff @(posedge clk) begin
		aluOpE_o <= aluOpD;
		useImmE_o <= useImmD;
		rsE_o <= rsD_o;
		rtE_o <= rtD_o;
		destE_o <= destD;
		srcAE_o <= rdataA;
		srcBE_o <= rdataB;
		immE_o <= immD;
		targetE_o <= targetD;
		pcE_o <= pcD;
	end

endmodule

// ==== executeStage.sv ====
module executeStage (
	input  logic                         clk,
	input  logic                         rst_i,
	input  cpuPkg::aluOpE               aluOpE_i,
	input  logic                         useImmE_i,
	input  logic                         regWriteE_i,
	input  logic                         memReadE_i,
	input  logic                         memWriteE_i,
	input  logic                         branchE_i,
	input  logic                         branchNeE_i,
	input  logic                         jumpE_i,
	input  logic [cpuPkg::regAddrW-1:0] destE_i,
	input  logic [cpuPkg::dataW-1:0]    srcAE_i,
	input  logic [cpuPkg::dataW-1:0]    srcBE_i,
	input  logic [cpuPkg::dataW-1:0]    immE_i,
	input  logic [cpuPkg::dataW-1:0]    targetE_i,
	input  logic [cpuPkg::dataW-1:0]    pcE_i,
	input  cpuPkg::fwdSelE              fwdA_i,
	input  cpuPkg::fwdSelE              fwdB_i,
	input  logic [cpuPkg::dataW-1:0]    memResult_i,
	input  logic [cpuPkg::dataW-1:0]    wbResult_i,
	output logic                         redirect_o,
	output logic [cpuPkg::dataW-1:0]    redirectTarget_o,
	output logic [cpuPkg::dataW-1:0]    aluResultM_o,
	output logic [cpuPkg::dataW-1:0]    storeDataM_o,
	output logic [cpuPkg::regAddrW-1:0] destM_o,
	output logic                         regWriteM_o,
	output logic                         memReadM_o,
	output logic                         memWriteM_o,
	output logic [cpuPkg::dataW-1:0]    pcM_o
);

	logic [cpuPkg::dataW-1:0] opA, opB, aluB, aluResult;

	function automatic logic [cpuPkg::dataW-1:0] pickOperand(
		input cpuPkg::fwdSelE sel,
		input logic [cpuPkg::dataW-1:0] regVal,
		input logic [cpuPkg::dataW-1:0] memVal,
		input logic [cpuPkg::dataW-1:0] wbVal
	);
		case (sel)
			cpuPkg::fromMem: return memVal;
			cpuPkg::fromWb:  return wbVal;
			default:         return regVal;
		endcase
	endfunction

	assign opA = pickOperand(fwdA_i, srcAE_i, memResult_i, wbResult_i);
	assign opB = pickOperand(fwdB_i, srcBE_i, memResult_i, wbResult_i);
	assign aluB = useImmE_i ? immE_i : opB;

	always_comb begin
		case (aluOpE_i)
			cpuPkg::aluSub:  aluResult = opA - aluB;
			cpuPkg::aluAnd:  aluResult = opA & aluB;
			cpuPkg::aluOr:   aluResult = opA | aluB;
			cpuPkg::aluXor:  aluResult = opA ^ aluB;
			cpuPkg::aluNor:  aluResult = ~(opA | aluB);
			cpuPkg::aluSlt:  aluResult = {{(cpuPkg::dataW-1){1'b0}}, $signed(opA) < $signed(aluB)};
			cpuPkg::aluSltu: aluResult = {{(cpuPkg::dataW-1){1'b0}}, opA < aluB};
			cpuPkg::aluLui:  aluResult = {aluB[15:0], 16'b0};
			default:         aluResult = opA + aluB;
		endcase
	end

	// Taken when equality disagrees with the bne flag.
	assign redirect_o = jumpE_i || (branchE_i && ((opA == opB) != branchNeE_i));
	assign redirectTarget_o = targetE_i;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			{regWriteM_o, memReadM_o, memWriteM_o} <= '0;
		end else begin
			{regWriteM_o, memReadM_o, memWriteM_o} <= {regWriteE_i, memReadE_i, memWriteE_i};
		end
	end

	always_ff @(posedge clk) begin
		aluResultM_o <= aluResult;
		storeDataM_o <= opB; // Forwarded rt.
		destM_o <= destE_i;
		pcM_o <= pcE_i;
	end

endmodule

// ==== fetchStage.sv ====
module fetchStage #(
	parameter logic [31:0] resetVector = 32'hbfc00000
) (
	input  logic                      clk,
	input  logic                      rst_i,
	input  logic                      stallF_i,
	input  logic                      redirect_i,
	input  logic [cpuPkg::dataW-1:0] redirectTarget_i,
	output logic [cpuPkg::dataW-1:0] pcF_o,
	output logic [cpuPkg::dataW-1:0] pcPlus4F_o,
	output logic                      instSramEn_o,
	output logic [cpuPkg::dataW-1:0] instSramAddr_o
);

	logic [cpuPkg::dataW-1:0] pc;

	always_ff @(posedge clk) begin
		if (rst_i) begin
			pc <= resetVector;
		end else if (redirect_i) begin
			pc <= redirectTarget_i; // Delay slot is already in decode.
		end else if (!stallF_i) begin
			pc <= pcPlus4F_o;
		end
	end

	assign pcF_o = pc;
	assign pcPlus4F_o = pc + 32'd4;

	// SRAM keeps its last word while the enable is low.
	assign instSramEn_o = !rst_i && !stallF_i;
	assign instSramAddr_o = pc;

endmodule

// ==== hazardUnit.sv ====
module hazardUnit (
	input  logic                         clk,
	input  logic                         rst_i,
	input  logic [cpuPkg::regAddrW-1:0] rsD_i,
	input  logic [cpuPkg::regAddrW-1:0] rtD_i,
	input  logic [cpuPkg::regAddrW-1:0] rsE_i,
	input  logic [cpuPkg::regAddrW-1:0] rtE_i,
	input  logic [cpuPkg::regAddrW-1:0] destE_i,
	input  logic                         memReadE_i,
	input  logic                         regWriteE_i,
	input  logic [cpuPkg::regAddrW-1:0] destM_i,
	input  logic                         regWriteM_i,
	input  logic [cpuPkg::regAddrW-1:0] destW_i,
	input  logic                         regWriteW_i,
	input  logic                         redirect_i,
	output logic                         stallF_o,
	output logic                         stallD_o,
	output logic                         flushD_o,
	output logic                         flushE_o,
	output cpuPkg::fwdSelE              fwdA_o,
	output cpuPkg::fwdSelE              fwdB_o
);

	logic redirectQ, loadUse;

	function automatic cpuPkg::fwdSelE pickSource(
		input logic [cpuPkg::regAddrW-1:0] src,
		input logic [cpuPkg::regAddrW-1:0] destM,
		input logic                         wenM,
		input logic [cpuPkg::regAddrW-1:0] destW,
		input logic                         wenW
	);
		if (src == '0) return cpuPkg::fromReg;
		if (wenM && destM == src) return cpuPkg::fromMem; // Youngest value first.
		if (wenW && destW == src) return cpuPkg::fromWb;
		return cpuPkg::fromReg;
	endfunction

	// Wrong-path word reaches decode one cycle after the redirect.
	always_ff @(posedge clk) begin
		if (rst_i) begin
			redirectQ <= 1'b0;
		end else begin
			redirectQ <= redirect_i;
		end
	end

	// A wrong-path word must not stall, or it would outlive flushD.
	assign loadUse = memReadE_i && regWriteE_i && destE_i != '0 && !redirectQ &&
		(destE_i == rsD_i || destE_i == rtD_i);

	assign stallF_o = loadUse;
	assign stallD_o = loadUse;
	assign flushE_o = loadUse; // Bubble into execute.
	assign flushD_o = redirectQ;
	assign fwdA_o = pickSource(rsE_i, destM_i, regWriteM_i, destW_i, regWriteW_i);
	assign fwdB_o = pickSource(rtE_i, destM_i, regWriteM_i, destW_i, regWriteW_i);

endmodule

// ==== memoryStage.sv ====
module memoryStage (
	input  logic                         clk,
	input  logic                         rst_i,
	input  logic [cpuPkg::dataW-1:0]    aluResultM_i,
	input  logic [cpuPkg::dataW-1:0]    storeDataM_i,
	input  logic [cpuPkg::regAddrW-1:0] destM_i,
	input  logic                         regWriteM_i,
	input  logic                         memReadM_i,
	input  logic                         memWriteM_i,
	input  logic [cpuPkg::dataW-1:0]    pcM_i,
	input  logic [cpuPkg::dataW-1:0]    dataSramRdata_i,
	output logic                         dataSramEn_o,
	output logic [3:0]                   dataSramWen_o,
	output logic [cpuPkg::dataW-1:0]    dataSramAddr_o,
	output logic [cpuPkg::dataW-1:0]    dataSramWdata_o,
	output logic [cpuPkg::dataW-1:0]    memResult_o,
	output logic                         wbWen_o,
	output logic [cpuPkg::regAddrW-1:0] wbAddr_o,
	output logic [cpuPkg::dataW-1:0]    wbData_o,
	output logic [cpuPkg::dataW-1:0]    debugWbPc_o
);

	logic memReadW;
	logic [cpuPkg::dataW-1:0] aluResultW;

	assign dataSramEn_o = memReadM_i || memWriteM_i;
	assign dataSramWen_o = {4{memWriteM_i}}; // Whole words only.
	assign dataSramAddr_o = {{(cpuPkg::dataW-cpuPkg::physAddrBits){1'b0}},
		aluResultM_i[cpuPkg::physAddrBits-1:0]};
	assign dataSramWdata_o = storeDataM_i;
	assign memResult_o = aluResultM_i; // Loads never forward from here.

	always_ff @(posedge clk) begin
		if (rst_i) begin
			wbWen_o <= 1'b0;
			memReadW <= 1'b0;
		end else begin
			wbWen_o <= regWriteM_i && destM_i != '0;
			memReadW <= memReadM_i;
		end
	end

	always_ff @(posedge clk) begin
		aluResultW <= aluResultM_i;
		wbAddr_o <= destM_i;
		debugWbPc_o <= pcM_i;
	end

	// Read data arrives one cycle after the request.
	assign wbData_o = memReadW ? dataSramRdata_i : aluResultW;

endmodule

// ==== mycpuProps.sv ====
module mycpuProps #(
	parameter logic [31:0] resetVector = 32'hbfc00000
) (
	input logic        clk,
	input logic        rst_i,
	input logic        instSramEn_i,
	input logic [31:0] instSramAddr_i,
	input logic        dataSramEn_i,
	input logic [3:0]  dataSramWen_i,
	input logic [31:0] dataSramAddr_i,
	input logic [31:0] dataSramWdata_i,
	input logic [31:0] debugWbPc_i,
	input logic [3:0]  debugWbRfWen_i,
	input logic [4:0]  debugWbRfWnum_i,
	input logic [31:0] debugWbRfWdata_i,
	input logic        expWbValid_i,
	input logic [31:0] expPc_i,
	input logic [4:0]  expReg_i,
	input logic [31:0] expVal_i,
	input logic        expStValid_i,
	input logic [31:0] expStAddr_i,
	input logic [31:0] expStData_i
);

	int failCount = 0; // Watched by the testbench.
	logic wbFire, stFire;

	assign wbFire = debugWbRfWen_i != '0;
	assign stFire = dataSramWen_i != '0;

	resetFetch: assert property (@(posedge clk) $fell(rst_i) |->
		instSramEn_i && instSramAddr_i == resetVector)
		else begin
			failCount++;
			$error("Error in resetFetch: expected address %h, actual %h (enable %b)",
				resetVector, $sampled(instSramAddr_i), $sampled(instSramEn_i));
		end

	resetQuiet: assert property (@(posedge clk) rst_i |=>
		dataSramWen_i == '0 && debugWbRfWen_i == '0)
		else begin
			failCount++;
			$error("Error in resetQuiet: expected enables 0/0, actual %h/%h",
				$sampled(dataSramWen_i), $sampled(debugWbRfWen_i));
		end

	wbPending: assert property (@(posedge clk) disable iff (rst_i) wbFire |-> expWbValid_i)
		else begin
			failCount++;
			$error("Error in writebackOrder: a writeback retired with none expected");
		end

	wbMatch: assert property (@(posedge clk) disable iff (rst_i) wbFire && expWbValid_i |->
		debugWbPc_i == expPc_i && debugWbRfWnum_i == expReg_i && debugWbRfWdata_i == expVal_i)
		else begin
			failCount++;
			$error("Error in writebackOrder: expected pc %h r%0d %h, actual pc %h r%0d %h",
				$sampled(expPc_i), $sampled(expReg_i), $sampled(expVal_i),
				$sampled(debugWbPc_i), $sampled(debugWbRfWnum_i), $sampled(debugWbRfWdata_i));
		end

	// Register 0 must never show up in the trace.
	regZero: assert property (@(posedge clk) disable iff (rst_i) wbFire |-> debugWbRfWnum_i != '0)
		else begin
			failCount++;
			$error("Error in registerZero: the trace reports a write to register 0");
		end

	stEnable: assert property (@(posedge clk) disable iff (rst_i) stFire |->
		dataSramWen_i == 4'hf && dataSramEn_i && expStValid_i)
		else begin
			failCount++;
			$error("Error in storeEnable: expected wen f with a store pending, actual %h",
				$sampled(dataSramWen_i));
		end

	stMatch: assert property (@(posedge clk) disable iff (rst_i) stFire && expStValid_i |->
		dataSramAddr_i == expStAddr_i && dataSramWdata_i == expStData_i)
		else begin
			failCount++;
			$error("Error in storeOrder: expected %h <- %h, actual %h <- %h",
				$sampled(expStAddr_i), $sampled(expStData_i),
				$sampled(dataSramAddr_i), $sampled(dataSramWdata_i));
		end

endmodule

// ==== mycpuTop.sv ====
module mycpuTop #(
	parameter logic [31:0] resetVector = 32'hbfc00000
) (
	input  logic                         clk,
	input  logic                         rst_i,
	input  logic [cpuPkg::dataW-1:0]    instSramRdata_i,
	input  logic [cpuPkg::dataW-1:0]    dataSramRdata_i,
	output logic                         instSramEn_o,
	output logic [cpuPkg::dataW-1:0]    instSramAddr_o,
	output logic                         dataSramEn_o,
	output logic [3:0]                   dataSramWen_o,
	output logic [cpuPkg::dataW-1:0]    dataSramAddr_o,
	output logic [cpuPkg::dataW-1:0]    dataSramWdata_o,
	output logic [cpuPkg::dataW-1:0]    debugWbPc_o,
	output logic [3:0]                   debugWbRfWen_o,
	output logic [cpuPkg::regAddrW-1:0] debugWbRfWnum_o,
	output logic [cpuPkg::dataW-1:0]    debugWbRfWdata_o
);

	logic stallF, stallD, flushD, flushE, redirect;
	logic useImmE, regWriteE, memReadE, memWriteE, branchE, branchNeE, jumpE;
	logic regWriteM, memReadM, memWriteM, wbWen;
	logic [cpuPkg::regAddrW-1:0] rsD, rtD, rsE, rtE, destE, destM, wbAddr;
	logic [cpuPkg::dataW-1:0] redirectTarget, pcF, pcPlus4F, srcAE, srcBE, immE, targetE, pcE;
	logic [cpuPkg::dataW-1:0] aluResultM, storeDataM, pcM, memResult, wbData;
	cpuPkg::aluOpE aluOpE;
	cpuPkg::fwdSelE fwdA, fwdB;

	assign debugWbRfWen_o = {4{wbWen}};
	assign debugWbRfWnum_o = wbAddr;
	assign debugWbRfWdata_o = wbData;

	fetchStage #(.resetVector(resetVector)) i_fetchStage (
		.clk(clk), .rst_i(rst_i), .stallF_i(stallF),
		.redirect_i(redirect), .redirectTarget_i(redirectTarget),
		.pcF_o(pcF), .pcPlus4F_o(pcPlus4F),
		.instSramEn_o(instSramEn_o), .instSramAddr_o(instSramAddr_o)
	);

	decodeStage i_decodeStage (
		.clk(clk), .rst_i(rst_i), .stallD_i(stallD), .flushD_i(flushD), .flushE_i(flushE),
		.instr_i(instSramRdata_i), .pcPlus4F_i(pcPlus4F), .pcF_i(pcF),
		.wbWen_i(wbWen), .wbAddr_i(wbAddr), .wbData_i(wbData),
		.rsD_o(rsD), .rtD_o(rtD), .aluOpE_o(aluOpE), .useImmE_o(useImmE),
		.regWriteE_o(regWriteE), .memReadE_o(memReadE), .memWriteE_o(memWriteE),
		.branchE_o(branchE), .branchNeE_o(branchNeE), .jumpE_o(jumpE),
		.rsE_o(rsE), .rtE_o(rtE), .destE_o(destE), .srcAE_o(srcAE), .srcBE_o(srcBE),
		.immE_o(immE), .targetE_o(targetE), .pcE_o(pcE)
	);

	executeStage i_executeStage (
		.clk(clk), .rst_i(rst_i), .aluOpE_i(aluOpE), .useImmE_i(useImmE),
		.regWriteE_i(regWriteE), .memReadE_i(memReadE), .memWriteE_i(memWriteE),
		.branchE_i(branchE), .branchNeE_i(branchNeE), .jumpE_i(jumpE),
		.destE_i(destE), .srcAE_i(srcAE), .srcBE_i(srcBE), .immE_i(immE),
		.targetE_i(targetE), .pcE_i(pcE), .fwdA_i(fwdA), .fwdB_i(fwdB),
		.memResult_i(memResult), .wbResult_i(wbData),
		.redirect_o(redirect), .redirectTarget_o(redirectTarget),
		.aluResultM_o(aluResultM), .storeDataM_o(storeDataM), .destM_o(destM),
		.regWriteM_o(regWriteM), .memReadM_o(memReadM), .memWriteM_o(memWriteM),
		.pcM_o(pcM)
	);

	memoryStage i_memoryStage (
		.clk(clk), .rst_i(rst_i), .aluResultM_i(aluResultM), .storeDataM_i(storeDataM),
		.destM_i(destM), .regWriteM_i(regWriteM), .memReadM_i(memReadM),
		.memWriteM_i(memWriteM), .pcM_i(pcM), .dataSramRdata_i(dataSramRdata_i),
		.dataSramEn_o(dataSramEn_o), .dataSramWen_o(dataSramWen_o),
		.dataSramAddr_o(dataSramAddr_o), .dataSramWdata_o(dataSramWdata_o),
		.memResult_o(memResult), .wbWen_o(wbWen), .wbAddr_o(wbAddr), .wbData_o(wbData),
		.debugWbPc_o(debugWbPc_o)
	);

	hazardUnit i_hazardUnit (
		.clk(clk), .rst_i(rst_i), .rsD_i(rsD), .rtD_i(rtD), .rsE_i(rsE), .rtE_i(rtE),
		.destE_i(destE), .memReadE_i(memReadE), .regWriteE_i(regWriteE),
		.destM_i(destM), .regWriteM_i(regWriteM), .destW_i(wbAddr), .regWriteW_i(wbWen),
		.redirect_i(redirect), .stallF_o(stallF), .stallD_o(stallD),
		.flushD_o(flushD), .flushE_o(flushE), .fwdA_o(fwdA), .fwdB_o(fwdB)
	);

endmodule

// ==== project.f ====
cpuPkg.sv
regFile.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
memoryStage.sv
hazardUnit.sv
mycpuTop.sv
mycpuProps.sv
tbMycpu.sv

// ==== regFile.sv ====
module regFile (
	input  logic                         clk,
	input  logic                         rst_i,
	input  logic [cpuPkg::regAddrW-1:0] raddrA_i,
	input  logic [cpuPkg::regAddrW-1:0] raddrB_i,
	input  logic [cpuPkg::regAddrW-1:0] waddr_i,
	input  logic                         wen_i,
	input  logic [cpuPkg::dataW-1:0]    wdata_i,
	output logic [cpuPkg::dataW-1:0]    rdataA_o,
	output logic [cpuPkg::dataW-1:0]    rdataB_o
);

	logic [cpuPkg::dataW-1:0] regs [32]; // Entry 0 is never written.

	always_ff @(posedge clk) begin
		if (wen_i && !rst_i && waddr_i != '0) begin
			regs[waddr_i] <= wdata_i;
		end
	end

	// Writeback in the same cycle wins over the array.
	assign rdataA_o = (raddrA_i == '0) ? '0 :
		(wen_i && waddr_i == raddrA_i) ? wdata_i : regs[raddrA_i];
	assign rdataB_o = (raddrB_i == '0) ? '0 :
		(wen_i && waddr_i == raddrB_i) ? wdata_i : regs[raddrB_i];

endmodule

// ==== tbMycpu.sv ====
module tbMycpu;

	localparam logic [31:0] resetVector = 32'hbfc00000;
	localparam int randomCount = 60;
	localparam cpuPkg::functE functs [8] = '{cpuPkg::ADDU, cpuPkg::SUBU, cpuPkg::AND,
		cpuPkg::OR, cpuPkg::XOR, cpuPkg::NOR, cpuPkg::SLT, cpuPkg::SLTU};
	localparam cpuPkg::opcodeE immOps [5] = '{cpuPkg::ADDIU, cpuPkg::SLTI, cpuPkg::ANDI,
		cpuPkg::ORI, cpuPkg::LUI};

	logic clk, rst_i, instSramEn, dataSramEn;
	logic [31:0] instSramRdata, dataSramRdata, instSramAddr, dataSramAddr, dataSramWdata;
	logic [31:0] debugWbPc, debugWbRfWdata;
	logic [3:0] dataSramWen, debugWbRfWen;
	logic [4:0] debugWbRfWnum;

	logic [31:0] imem [256];
	logic [31:0] dmem [256];
	int progLen, loopIdx, k;
	logic [68:0] wbQ [$]; // {pc, reg, value}
	logic [63:0] stQ [$]; // {address, data}
	logic [31:0] expPc, expVal, expStAddr, expStData;
	logic [4:0] expReg;
	logic expWbValid, expStValid;

	mycpuTop #(.resetVector(resetVector)) i_mycpuTop (
		.clk(clk), .rst_i(rst_i), .instSramRdata_i(instSramRdata),
		.dataSramRdata_i(dataSramRdata), .instSramEn_o(instSramEn),
		.instSramAddr_o(instSramAddr), .dataSramEn_o(dataSramEn), .dataSramWen_o(dataSramWen),
		.dataSramAddr_o(dataSramAddr), .dataSramWdata_o(dataSramWdata),
		.debugWbPc_o(debugWbPc), .debugWbRfWen_o(debugWbRfWen),
		.debugWbRfWnum_o(debugWbRfWnum), .debugWbRfWdata_o(debugWbRfWdata)
	);

	bind mycpuTop mycpuProps #(.resetVector(resetVector)) i_props (
		.clk(clk), .rst_i(rst_i), .instSramEn_i(instSramEn_o), .instSramAddr_i(instSramAddr_o),
		.dataSramEn_i(dataSramEn_o), .dataSramWen_i(dataSramWen_o),
		.dataSramAddr_i(dataSramAddr_o), .dataSramWdata_i(dataSramWdata_o),
		.debugWbPc_i(debugWbPc_o), .debugWbRfWen_i(debugWbRfWen_o),
		.debugWbRfWnum_i(debugWbRfWnum_o), .debugWbRfWdata_i(debugWbRfWdata_o),
		.expWbValid_i(tbMycpu.expWbValid), .expPc_i(tbMycpu.expPc),
		.expReg_i(tbMycpu.expReg), .expVal_i(tbMycpu.expVal),
		.expStValid_i(tbMycpu.expStValid), .expStAddr_i(tbMycpu.expStAddr),
		.expStData_i(tbMycpu.expStData)
	);

	function automatic logic [31:0] fillWord(int idx);
		return (32'(idx) * 32'h9e3779b1) ^ 32'h5a5a0000;
	endfunction

	function automatic logic [31:0] rType(cpuPkg::functE fn, int rs, int rt, int rd);
		return {6'(cpuPkg::SPECIAL), 5'(rs), 5'(rt), 5'(rd), 5'd0, 6'(fn)};
	endfunction

	function automatic logic [31:0] iType(cpuPkg::opcodeE op, int rs, int rt, logic [15:0] imm);
		return {6'(op), 5'(rs), 5'(rt), imm};
	endfunction

	function automatic logic [31:0] jType(int targetIdx);
		logic [31:0] dest;
		dest = resetVector + 32'(targetIdx) * 4;
		return {6'(cpuPkg::J), dest[27:2]};
	endfunction

	function automatic int pickReg();
		return 1 + int'($urandom % 7);
	endfunction

	task automatic emit(logic [31:0] word);
		imem[progLen] = word;
		progLen++;
	endtask

	// Control words never sit in a delay slot and never jump past the final loop.
	task automatic emitRandom(int endIdx);
		int n, kind, off;
		bit lastCtrl;
		cpuPkg::opcodeE op;
		lastCtrl = 1'b0;
		for (n = 0; n < randomCount; n++) begin
			kind = int'($urandom % 10);
			off = 1 + int'($urandom % 3);
			if (kind >= 8 && (lastCtrl || progLen + 1 + off > endIdx)) begin
				kind = int'($urandom % 8);
			end
			case (kind)
				0, 1, 2: emit(rType(functs[$urandom % 8], pickReg(), pickReg(), pickReg()));
				3, 4: begin
					op = immOps[$urandom % 5];
					emit(iType(op, (op == cpuPkg::LUI) ? 0 : pickReg(), pickReg(), 16'($urandom)));
				end
				5, 7: emit(iType(cpuPkg::LW, 0, pickReg(), 16'(4 * ($urandom % 16))));
				6: emit(iType(cpuPkg::SW, 0, pickReg(), 16'(4 * ($urandom % 16))));
				8: emit(iType(($urandom % 2) ? cpuPkg::BEQ : cpuPkg::BNE, pickReg(), pickReg(),
					16'(off)));
				default: emit(jType(progLen + 1 + off));
			endcase
			lastCtrl = kind >= 8;
		end
	endtask

	task automatic buildProgram();
		progLen = 0;
		for (k = 0; k < 256; k++) begin
			imem[k] = '0;
			dmem[k] = fillWord(k);
		end
		for (k = 1; k < 8; k++) begin
			emit(iType(cpuPkg::ADDIU, 0, k, 16'(k * 291 - 900)));
		end
		emit(iType(cpuPkg::ADDIU, 1, 0, 16'd5)); // Writes to register 0.
		emit(rType(cpuPkg::ADDU, 1, 2, 0));
		emit(rType(cpuPkg::ADDU, 1, 2, 3));
		emit(rType(cpuPkg::SUBU, 3, 1, 4)); // From memory.
		emit(rType(cpuPkg::XOR, 3, 4, 5)); // From writeback and memory.
		emit(iType(cpuPkg::LUI, 0, 6, 16'ha000));
		emit(iType(cpuPkg::SW, 6, 5, 16'd8)); // Top bits mapped away.
		emit(iType(cpuPkg::LW, 6, 7, 16'd8));
		emit(rType(cpuPkg::ADDU, 7, 7, 1)); // Load-use pair.
		emit(iType(cpuPkg::LW, 0, 2, 16'd12));
		emit(rType(cpuPkg::OR, 1, 2, 3));
		emit(iType(cpuPkg::BEQ, 1, 1, 16'd2)); // Taken.
		emit(iType(cpuPkg::ADDIU, 2, 2, 16'd1));
		emit(iType(cpuPkg::ADDIU, 2, 2, 16'd100));
		emit(iType(cpuPkg::BNE, 3, 3, 16'd2)); // Falls through.
		emit(iType(cpuPkg::ADDIU, 3, 3, 16'd1));
		emit(iType(cpuPkg::ADDIU, 3, 3, 16'd2));
		emit(jType(progLen + 3));
		emit(iType(cpuPkg::ORI, 4, 4, 16'h00f0));
		emit(iType(cpuPkg::ADDIU, 4, 4, 16'd7));
		emitRandom(progLen + randomCount);
		loopIdx = progLen;
		emit(jType(progLen)); // Spin here.
		emit(32'h0);
	endtask

	// Instruction-level model with one delay slot per control transfer.
	task automatic runReference();
		logic [31:0] regs [32];
		logic [31:0] ram [256];
		logic [31:0] pc, npc, nnpc, ins, a, b, simm, zimm, res, addr;
		logic [4:0] dest;
		logic wr, taken;
		int i, steps;
		for (i = 0; i < 256; i++) begin
			ram[i] = fillWord(i);
		end
		regs[0] = '0;
		pc = resetVector;
		npc = pc + 4;
		steps = 0;
		while (pc != resetVector + 32'(loopIdx) * 4 && steps < 4000) begin
			ins = imem[pc[9:2]];
			a = regs[ins[25:21]];
			b = regs[ins[20:16]];
			simm = {{16{ins[15]}}, ins[15:0]};
			zimm = {16'b0, ins[15:0]};
			addr = (a + simm) & 32'h1fffffff;
			nnpc = npc + 4;
			wr = 1'b1;
			dest = ins[20:16];
			res = '0;
			case (cpuPkg::opcodeE'(ins[31:26]))
				cpuPkg::SPECIAL: begin
					dest = ins[15:11];
					case (cpuPkg::functE'(ins[5:0]))
						cpuPkg::ADDU: res = a + b;
						cpuPkg::SUBU: res = a - b;
						cpuPkg::AND:  res = a & b;
						cpuPkg::OR:   res = a | b;
						cpuPkg::XOR:  res = a ^ b;
						cpuPkg::NOR:  res = ~(a | b);
						cpuPkg::SLT:  res = 32'($signed(a) < $signed(b));
						cpuPkg::SLTU: res = 32'(a < b);
						default:      wr = 1'b0;
					endcase
				end
				cpuPkg::ADDIU: res = a + simm;
				cpuPkg::SLTI:  res = 32'($signed(a) < $signed(simm));
				cpuPkg::ANDI:  res = a & zimm;
				cpuPkg::ORI:   res = a | zimm;
				cpuPkg::LUI:   res = {ins[15:0], 16'b0};
				cpuPkg::LW:    res = ram[addr[9:2]];
				cpuPkg::SW: begin
					wr = 1'b0;
					ram[addr[9:2]] = b;
					stQ.push_back({addr, b});
				end
				cpuPkg::BEQ, cpuPkg::BNE: begin
					wr = 1'b0;
					taken = (ins[31:26] == 6'(cpuPkg::BEQ)) ? (a == b) : (a != b);
					if (taken) nnpc = npc + {simm[29:0], 2'b00};
				end
				cpuPkg::J: begin
					wr = 1'b0;
					nnpc = {npc[31:28], ins[25:0], 2'b00};
				end
				default: wr = 1'b0;
			endcase
			if (wr && dest != '0) begin
				regs[dest] = res;
				wbQ.push_back({pc, dest, res});
			end
			pc = npc;
			npc = nnpc;
			steps++;
		end
	endtask

	task automatic showHeads();
		expWbValid = wbQ.size() > 0;
		expStValid = stQ.size() > 0;
		if (expWbValid) {expPc, expReg, expVal} = wbQ[0];
		if (expStValid) {expStAddr, expStData} = stQ[0];
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	// Both SRAMs answer one cycle after an enabled edge.
	always @(posedge clk) begin : sramModels
		logic iEn, dEn;
		logic [3:0] dWen;
		logic [7:0] iIdx, dIdx;
		logic [31:0] dWdata;
		iEn = instSramEn;
		iIdx = instSramAddr[9:2];
		dEn = dataSramEn;
		dWen = dataSramWen;
		dIdx = dataSramAddr[9:2];
		dWdata = dataSramWdata;
		#2;
		if (iEn) instSramRdata = imem[iIdx];
		if (dEn) begin
			dataSramRdata = dmem[dIdx];
			for (int lane = 0; lane < 4; lane++) begin
				if (dWen[lane]) dmem[dIdx][8*lane +: 8] = dWdata[8*lane +: 8];
			end
		end
	end

	// Queue heads move on only after the checker has sampled them.
	always @(posedge clk) begin : retireTracker
		logic wbNow, stNow;
		wbNow = !rst_i && debugWbRfWen != '0;
		stNow = !rst_i && dataSramWen != '0;
		#2;
		if (wbNow && wbQ.size() > 0) void'(wbQ.pop_front());
		if (stNow && stQ.size() > 0) void'(stQ.pop_front());
		showHeads();
	end

	initial begin
		wait (i_mycpuTop.i_props.failCount != 0);
		$display("=== FAIL ===");
		$fatal(1, "The bound checker reported a failed assertion");
	end

	initial begin : watchdog
		@(negedge rst_i);
		repeat (2 * progLen * 6) @(posedge clk);
		$display("Watchdog expired, the pipeline stopped retiring instructions");
		$display("=== FAIL ===");
		$fatal(1, "Timeout");
	end

	initial begin
		rst_i = 1'b1;
		instSramRdata = '0;
		dataSramRdata = '0;
		void'($urandom(32'ha2da35f8));
		buildProgram();
		runReference();
		showHeads();
		repeat (4) @(posedge clk);
		#2 rst_i = 1'b0;
		while (wbQ.size() != 0 || stQ.size() != 0) @(posedge clk);
		repeat (10) @(posedge clk); // Catch stray retirements.
		if (i_mycpuTop.i_props.failCount == 0) begin
			$display("=== PASS ===");
			$finish;
		end else begin
			$display("=== FAIL ===");
			$fatal(1, "Assertion failures reported");
		end
	end

endmodule
